/* logic/sd_dat_pkg.sv */
package sd_dat_pkg;

    // ==================================================
    // Widths
    // ==================================================

    typedef logic [3:0]  nibble_t;       // One sample of DAT[3:0]
    typedef logic [7:0]  byte_t;
    typedef logic [10:0] fifo_count_t;   // 0 to FIFO_DEPTH inclusive
    typedef logic [7:0]  block_count_t;  // Blocks minus one
    typedef logic [10:0] beat_count_t;
    typedef logic [15:0] crc_t;

    // ==================================================
    // Frame geometry
    // ==================================================

    localparam int BLOCK_BYTES    = 512;
    localparam int BLOCK_NIBBLES  = 1024;
    localparam int CRC_BITS       = 16;
    localparam int FIFO_DEPTH     = 1024;
    localparam int STATUS_TIMEOUT = 8;     // Rising strobes allowed before the token start bit

    localparam crc_t CRC_POLY = 16'h1021;  // x^16 + x^12 + x^5 + 1

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT_START,
        RX_DATA,
        RX_CRC
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_WAIT_FIFO,
        TX_START,
        TX_DATA,
        TX_CRC,
        TX_END,
        TX_STATUS_WAIT,
        TX_STATUS
    } tx_state_t;

endpackage

/* logic/sd_fifo_if.sv */
`timescale 1ns/1ps

interface sd_fifo_if;
    import sd_dat_pkg::*;

    logic        write;
    byte_t       wdata;
    logic        full;
    logic        read;
    byte_t       rdata;
    logic        empty;
    fifo_count_t count;

    modport writer (output write, output wdata, input full, input count);

    modport reader (output read, input rdata, input empty, input count);

    modport storage (
        input  write,
        input  wdata,
        output full,
        input  read,
        output rdata,
        output empty,
        output count
    );

endinterface

/* logic/sd_crc16.sv */
`timescale 1ns/1ps

module sd_crc16 (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             update,
    input  logic             shift,
    input  logic             data,
    output sd_dat_pkg::crc_t crc
);
    import sd_dat_pkg::*;

    logic feedback;

    assign feedback = crc[CRC_BITS-1] ^ data;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= '0;
        end else if (update) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC_POLY : crc_t'(0));
        end else if (shift) begin
            crc <= {crc[CRC_BITS-2:0], 1'b0};  // Top bit is always the next one on the line
        end
    end

endmodule

/* logic/sd_byte_fifo.sv */
`timescale 1ns/1ps

module sd_byte_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    sd_fifo_if.storage port
);
    import sd_dat_pkg::*;

    byte_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_count_t                   count;
    logic                          do_write;
    logic                          do_read;

    assign do_write = port.write && !port.full;  // Writes to a full FIFO are dropped
    assign do_read  = port.read && !port.empty;

    assign port.full  = (count == fifo_count_t'(FIFO_DEPTH));
    assign port.empty = (count == '0);
    assign port.count = count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two so the pointers wrap
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_count_t'(do_write) - fifo_count_t'(do_read);
        end
    end

    // Storage and the read register
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= port.wdata;
        end
        if (do_read) begin
            port.rdata <= mem[rd_ptr];
        end
    end

endmodule

/* logic/sd_dat_rx.sv */
`timescale 1ns/1ps

module sd_dat_rx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stop,
    input  logic                     start,
    input  sd_dat_pkg::block_count_t blocks,
    input  logic                     sd_clk_rising,
    input  sd_dat_pkg::nibble_t      dat_in,
    sd_fifo_if.writer                fifo,
    output logic                     busy,
    output logic                     error
);
    import sd_dat_pkg::*;

    rx_state_t    state;
    beat_count_t  beat;
    block_count_t blocks_left;
    byte_t        byte_q;
    logic         write_q;
    logic         crc_clear;
    logic         crc_update;
    logic         crc_check;
    crc_t         crc [4];
    nibble_t      crc_msb;

    // ==================================================
    // Line CRCs
    // ==================================================

    assign crc_clear  = sd_clk_rising && (state == RX_WAIT_START) && !dat_in[0];
    assign crc_update = sd_clk_rising && (state == RX_DATA);
    assign crc_check  = sd_clk_rising && (state == RX_CRC) && (beat < beat_count_t'(CRC_BITS));

    for (genvar i = 0; i < 4; i++) begin : g_crc
        sd_crc16 u_crc (
            .clk    (clk),
            .rst    (rst),
            .clear  (crc_clear),
            .update (crc_update),
            .shift  (crc_check),
            .data   (dat_in[i]),
            .crc    (crc[i])
        );

        assign crc_msb[i] = crc[i][CRC_BITS-1];
    end

    // ==================================================
    // Frame FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst || stop) begin
            state       <= RX_IDLE;
            beat        <= '0;
            blocks_left <= '0;
            write_q     <= 1'b0;
        end else begin
            write_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start) begin
                        blocks_left <= blocks;
                        state       <= RX_WAIT_START;
                    end
                end
                RX_WAIT_START: begin
                    if (sd_clk_rising && !dat_in[0]) begin
                        beat  <= '0;
                        state <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sd_clk_rising) begin
                        write_q <= beat[0];  // Low nibble completes the byte
                        beat    <= beat + 1'b1;
                        if (beat == beat_count_t'(BLOCK_NIBBLES - 1)) begin
                            beat  <= '0;
                            state <= RX_CRC;
                        end
                    end
                end
                RX_CRC: begin
                    if (sd_clk_rising) begin
                        beat <= beat + 1'b1;
                        if (beat == beat_count_t'(CRC_BITS)) begin  // End nibble is not checked
                            if (blocks_left == '0) begin
                                state <= RX_IDLE;
                            end else begin
                                blocks_left <= blocks_left - 1'b1;
                                state       <= RX_WAIT_START;
                            end
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // High nibble arrives first
    always_ff @(posedge clk) begin
        if (crc_update) begin
            byte_q <= {byte_q[3:0], dat_in};
        end
    end

    assign fifo.write = write_q;
    assign fifo.wdata = byte_q;

    assign busy  = (state != RX_IDLE);
    assign error = (write_q && fifo.full) || (crc_check && (crc_msb != dat_in));

endmodule

/* logic/sd_dat_tx.sv */
`timescale 1ns/1ps

module sd_dat_tx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stop,
    input  logic                     start,
    input  sd_dat_pkg::block_count_t blocks,
    input  logic                     sd_clk_rising,
    input  logic                     sd_clk_falling,
    input  sd_dat_pkg::nibble_t      dat_in,
    sd_fifo_if.reader                fifo,
    output sd_dat_pkg::nibble_t      dat_out,
    output logic                     dat_oe,
    output logic                     busy,
    output logic                     error
);
    import sd_dat_pkg::*;

    tx_state_t    state;
    beat_count_t  beat;
    block_count_t blocks_left;
    byte_t        shreg;
    logic         load_q;
    logic         crc_clear;
    logic         crc_update;
    logic         crc_shift;
    crc_t         crc [4];
    nibble_t      crc_msb;
    logic         timeout;
    logic         token_bad;

    // ==================================================
    // Line CRCs
    // ==================================================

    assign crc_clear  = sd_clk_falling && (state == TX_START);
    assign crc_update = sd_clk_falling && (state == TX_DATA);
    assign crc_shift  = sd_clk_falling && (state == TX_CRC);

    for (genvar i = 0; i < 4; i++) begin : g_crc
        sd_crc16 u_crc (
            .clk    (clk),
            .rst    (rst),
            .clear  (crc_clear),
            .update (crc_update),
            .shift  (crc_shift),
            .data   (shreg[4 + i]),
            .crc    (crc[i])
        );

        assign crc_msb[i] = crc[i][CRC_BITS-1];
    end

    // Next byte is fetched one strobe before its high nibble goes out
    assign fifo.read = sd_clk_falling && ((state == TX_START) ||
                       ((state == TX_DATA) && beat[0] &&
                        (beat != beat_count_t'(BLOCK_NIBBLES - 1))));

    assign timeout   = sd_clk_rising && (state == TX_STATUS_WAIT) && dat_in[0] &&
                       (beat == beat_count_t'(STATUS_TIMEOUT - 1));
    assign token_bad = sd_clk_rising && (state == TX_STATUS) && (dat_in[0] != beat[0]);

    // ==================================================
    // Frame FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst || stop) begin
            state       <= TX_IDLE;
            beat        <= '0;
            blocks_left <= '0;
            load_q      <= 1'b0;
            dat_out     <= 4'hF;
            dat_oe      <= 1'b0;
        end else begin
            load_q <= fifo.read && !fifo.empty;
            if (sd_clk_falling && ((state == TX_STATUS_WAIT) || (state == TX_STATUS))) begin
                dat_oe <= 1'b0;  // End nibble has had its full period
            end
            case (state)
                TX_IDLE: begin
                    if (start) begin
                        blocks_left <= blocks;
                        state       <= TX_WAIT_FIFO;
                    end
                end
                TX_WAIT_FIFO: begin
                    if (sd_clk_falling && (fifo.count >= fifo_count_t'(BLOCK_BYTES))) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (sd_clk_falling) begin
                        dat_out <= 4'h0;
                        dat_oe  <= 1'b1;
                        beat    <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (sd_clk_falling) begin
                        dat_out <= shreg[7:4];
                        beat    <= beat + 1'b1;
                        if (beat == beat_count_t'(BLOCK_NIBBLES - 1)) begin
                            beat  <= '0;
                            state <= TX_CRC;
                        end
                    end
                end
                TX_CRC: begin
                    if (sd_clk_falling) begin
                        dat_out <= crc_msb;
                        beat    <= beat + 1'b1;
                        if (beat == beat_count_t'(CRC_BITS - 1)) begin
                            state <= TX_END;
                        end
                    end
                end
                TX_END: begin
                    if (sd_clk_falling) begin
                        dat_out <= 4'hF;
                        beat    <= '0;
                        state   <= TX_STATUS_WAIT;
                    end
                end
                TX_STATUS_WAIT: begin
                    if (sd_clk_rising) begin
                        if (!dat_in[0]) begin
                            beat  <= '0;
                            state <= TX_STATUS;
                        end else if (timeout) begin
                            state <= TX_IDLE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                TX_STATUS: begin
                    if (sd_clk_rising) begin
                        beat <= beat + 1'b1;
                        if (token_bad) begin
                            state <= TX_IDLE;
                        end else if (beat == beat_count_t'(3)) begin  // Token 0,1,0 and end bit seen
                            if (blocks_left == '0) begin
                                state <= TX_IDLE;
                            end else begin
                                blocks_left <= blocks_left - 1'b1;
                                state       <= TX_WAIT_FIFO;
                            end
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Loaded byte is shifted out high nibble first
    always_ff @(posedge clk) begin
        if (load_q) begin
            shreg <= fifo.rdata;
        end else if (crc_update) begin
            shreg <= {shreg[3:0], 4'h0};
        end
    end

    assign busy  = (state != TX_IDLE);
    assign error = timeout || token_bad;

endmodule

/* logic/sd_dat.sv */
`timescale 1ns/1ps

module sd_dat (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_read,
    input  logic                     start_write,
    input  logic                     stop,
    input  logic                     flush,
    input  sd_dat_pkg::block_count_t blocks,
    input  logic                     sd_clk_rising,
    input  logic                     sd_clk_falling,
    input  sd_dat_pkg::nibble_t      dat_in,
    output sd_dat_pkg::nibble_t      dat_out,
    output logic                     dat_oe,
    input  logic                     rx_read,
    output sd_dat_pkg::byte_t        rx_rdata,
    output logic                     rx_empty,
    output sd_dat_pkg::fifo_count_t  rx_count,
    input  logic                     tx_write,
    input  sd_dat_pkg::byte_t        tx_wdata,
    output logic                     tx_full,
    output sd_dat_pkg::fifo_count_t  tx_count,
    output logic                     busy,
    output logic                     error,
    output logic                     card_busy
);
    import sd_dat_pkg::*;

    nibble_t dat_in_q;
    nibble_t tx_dat_out;
    logic    tx_dat_oe;
    logic    accept;
    logic    start_rx;
    logic    start_tx;
    logic    rx_busy;
    logic    tx_busy;
    logic    rx_error;
    logic    tx_error;
    logic    error_q;

    sd_fifo_if rx_fifo ();
    sd_fifo_if tx_fifo ();

    // ==================================================
    // Pad registers
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            dat_in_q  <= 4'hF;
            dat_out   <= 4'hF;
            dat_oe    <= 1'b0;
            card_busy <= 1'b0;
        end else begin
            dat_in_q  <= dat_in;
            dat_out   <= tx_dat_out;
            dat_oe    <= tx_dat_oe;
            card_busy <= !dat_in_q[0];  // Card holds DAT0 low while busy
        end
    end

    // Host sides of the two FIFOs
    assign rx_fifo.read  = rx_read;
    assign rx_rdata      = rx_fifo.rdata;
    assign rx_empty      = rx_fifo.empty;
    assign rx_count      = rx_fifo.count;
    assign tx_fifo.write = tx_write;
    assign tx_fifo.wdata = tx_wdata;
    assign tx_full       = tx_fifo.full;
    assign tx_count      = tx_fifo.count;

    sd_byte_fifo u_rx_fifo (.clk(clk), .rst(rst), .flush(flush), .port(rx_fifo.storage));
    sd_byte_fifo u_tx_fifo (.clk(clk), .rst(rst), .flush(flush), .port(tx_fifo.storage));

    // ==================================================
    // Start arbitration and paths
    // ==================================================

    assign accept   = (start_read || start_write) && !busy;
    assign start_tx = accept && start_write;  // Write wins a tie
    assign start_rx = accept && !start_write;

    sd_dat_rx u_rx (
        .clk           (clk),
        .rst           (rst),
        .stop          (stop),
        .start         (start_rx),
        .blocks        (blocks),
        .sd_clk_rising (sd_clk_rising),
        .dat_in        (dat_in_q),
        .fifo          (rx_fifo.writer),
        .busy          (rx_busy),
        .error         (rx_error)
    );

    sd_dat_tx u_tx (
        .clk            (clk),
        .rst            (rst),
        .stop           (stop),
        .start          (start_tx),
        .blocks         (blocks),
        .sd_clk_rising  (sd_clk_rising),
        .sd_clk_falling (sd_clk_falling),
        .dat_in         (dat_in_q),
        .fifo           (tx_fifo.reader),
        .dat_out        (tx_dat_out),
        .dat_oe         (tx_dat_oe),
        .busy           (tx_busy),
        .error          (tx_error)
    );

    assign busy = rx_busy || tx_busy;

    always_ff @(posedge clk) begin
        if (rst || accept) begin
            error_q <= 1'b0;
        end else if (rx_error || tx_error) begin
            error_q <= 1'b1;
        end
    end

    // Pulses show up at once while the path is still busy
    assign error = error_q || rx_error || tx_error;

endmodule

/* test/sd_dat_sva.sv */
`timescale 1ns/1ps

module sd_dat_sva (
    input logic clk,
    input logic rst,
    input logic rx_busy,
    input logic dat_oe,
    input logic busy,
    input logic error
);

    // ==================================================
    // Line ownership and status flags
    // ==================================================

    a_no_drive_in_read : assert property (
        @(posedge clk) disable iff (rst) rx_busy |-> !dat_oe
    ) else $error("dat_oe is high while a read is active");

    a_idle_after_reset : assert property (
        @(posedge clk) rst |=> !busy
    ) else $error("busy is high in the clock after reset");

    a_error_needs_busy : assert property (
        @(posedge clk) disable iff (rst) $rose(error) |-> busy  // Path pulses come while it is busy
    ) else $error("error rose while the engine was idle");

endmodule

/* test/sd_dat_tb.sv */
`timescale 1ns/1ps

module sd_dat_tb;
    import sd_dat_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int FRAME_NIBBLES = BLOCK_NIBBLES + CRC_BITS + 2;  // Start, data, CRC and end
    localparam int TEST_BLOCKS   = 8;
    localparam int LIMIT_CYCLES  = TEST_BLOCKS * (FRAME_NIBBLES + 24) * 4 + 10000;

    logic         clk;
    logic         rst;
    logic         start_read;
    logic         start_write;
    logic         stop;
    logic         flush;
    block_count_t blocks;
    logic         sd_clk_rising;
    logic         sd_clk_falling;
    nibble_t      dat_in;
    nibble_t      dat_out;
    logic         dat_oe;
    logic         rx_read;
    byte_t        rx_rdata;
    logic         rx_empty;
    fifo_count_t  rx_count;
    logic         tx_write;
    byte_t        tx_wdata;
    logic         tx_full;
    fifo_count_t  tx_count;
    logic         busy;
    logic         error;
    logic         card_busy;

    byte_t        data_mem [2 * BLOCK_BYTES];
    crc_t         ref_crc [4];
    logic [31:0]  rng;

    sd_dat UUT (
        .clk(clk), .rst(rst), .start_read(start_read), .start_write(start_write),
        .stop(stop), .flush(flush), .blocks(blocks),
        .sd_clk_rising(sd_clk_rising), .sd_clk_falling(sd_clk_falling),
        .dat_in(dat_in), .dat_out(dat_out), .dat_oe(dat_oe),
        .rx_read(rx_read), .rx_rdata(rx_rdata), .rx_empty(rx_empty), .rx_count(rx_count),
        .tx_write(tx_write), .tx_wdata(tx_wdata), .tx_full(tx_full), .tx_count(tx_count),
        .busy(busy), .error(error), .card_busy(card_busy)
    );

    bind sd_dat sd_dat_sva u_sva (
        .clk(clk), .rst(rst), .rx_busy(rx_busy), .dat_oe(dat_oe), .busy(busy), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sd_clk strobes alternate rising and falling two clocks apart
    initial begin : strobe_gen
        int phase;
        phase = 0;
        sd_clk_rising  = 1'b0;
        sd_clk_falling = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            sd_clk_rising  = (phase == 0);
            sd_clk_falling = (phase == 2);
            phase = (phase + 1) % 4;
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        stop_on_failure();
    end

    // ==================================================
    // Checks
    // ==================================================

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input fifo_count_t got, input fifo_count_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // ==================================================
    // Stimulus and reference model
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_random(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            rng = xorshift(rng);
            data_mem[i] = rng[7:0];
        end
    endtask

    // Nibble idx of a frame where the start nibble is number 0
    function automatic nibble_t frame_nibble(input int base, input int idx);
        byte_t   b;
        nibble_t n;
        int      k;
        int      l;
        n = 4'hF;
        if (idx == 0) begin
            n = 4'h0;
        end else if (idx <= BLOCK_NIBBLES) begin
            b = data_mem[base + (idx - 1) / 2];
            n = ((idx - 1) % 2 == 0) ? b[7:4] : b[3:0];  // High nibble first
        end else if (idx <= BLOCK_NIBBLES + CRC_BITS) begin
            k = idx - BLOCK_NIBBLES - 1;
            for (l = 0; l < 4; l++) begin
                n[l] = ref_crc[l][CRC_BITS - 1 - k];
            end
        end
        return n;
    endfunction

    task automatic compute_crcs(input int base);
        nibble_t n;
        logic    fb;
        int      i;
        int      l;
        for (l = 0; l < 4; l++) begin
            ref_crc[l] = 16'h0000;
        end
        for (i = 1; i <= BLOCK_NIBBLES; i++) begin
            n = frame_nibble(base, i);
            for (l = 0; l < 4; l++) begin
                fb = ref_crc[l][15] ^ n[l];
                ref_crc[l] = {ref_crc[l][14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // The card changes its lines on the falling strobe
    task automatic send_nibble(input nibble_t n);
        @(posedge sd_clk_falling);
        dat_in = n;
    endtask

    task automatic send_frame(input int base, input int flip_line, input int flip_bit,
                              input int data_nibbles);
        nibble_t n;
        int      idx;
        int      last;
        compute_crcs(base);
        send_nibble(4'hF);
        send_nibble(4'hF);
        last = (data_nibbles < BLOCK_NIBBLES) ? data_nibbles : FRAME_NIBBLES - 1;
        for (idx = 0; idx <= last; idx++) begin
            n = frame_nibble(base, idx);
            if (flip_line >= 0 && idx == BLOCK_NIBBLES + 1 + flip_bit) begin
                n[flip_line] = !n[flip_line];
            end
            send_nibble(n);
        end
    endtask

    // Samples the line on each rising strobe like a card does
    task automatic capture_frame(input int base);
        int idx;
        compute_crcs(base);
        idx = 0;
        while (idx < FRAME_NIBBLES) begin
            @(posedge sd_clk_rising);
            if (idx > 0) begin
                check_flag("dat_oe", dat_oe, 1'b1);
            end
            if (dat_oe) begin
                check_nibble("dat_out", dat_out, frame_nibble(base, idx));
                idx++;
            end
        end
    endtask

    task automatic send_token(input logic [2:0] bits);
        int i;
        send_nibble(4'hE);  // Start bit on DAT0
        for (i = 2; i >= 0; i--) begin
            send_nibble({3'b111, bits[i]});
        end
        send_nibble(4'hF);
    endtask

    task automatic issue_start(input logic write);
        start_write = write;
        start_read  = !write;
        tick();
        start_write = 1'b0;
        start_read  = 1'b0;
        check_flag("busy", busy, 1'b1);
        check_flag("error", error, 1'b0);
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (busy) begin
            tick();
            n++;
            if (n > limit) begin
                $display("busy did not fall within %0d clocks", limit);
                stop_on_failure();
            end
        end
    endtask

    task automatic load_tx(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            tx_write = 1'b1;
            tx_wdata = data_mem[i];
            tick();
        end
        tx_write = 1'b0;
    endtask

    task automatic drain_rx(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            rx_read = 1'b1;
            tick();
            check_byte("rx_rdata", rx_rdata, data_mem[i]);
        end
        rx_read = 1'b0;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        tick();
        flush = 1'b0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin : main
        int i;
        rng         = 32'h6110;
        rst         = 1'b1;
        start_read  = 1'b0;
        start_write = 1'b0;
        stop        = 1'b0;
        flush       = 1'b0;
        blocks      = '0;
        dat_in      = 4'hF;
        rx_read     = 1'b0;
        tx_write    = 1'b0;
        tx_wdata    = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_nibble("dat_out", dat_out, 4'hF);
        check_flag("dat_oe", dat_oe, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("error", error, 1'b0);

        fill_random(2 * BLOCK_BYTES);  // Two-block read
        blocks = 8'd1;
        issue_start(1'b0);
        send_frame(0, -1, 0, BLOCK_NIBBLES);
        send_frame(BLOCK_BYTES, -1, 0, BLOCK_NIBBLES);
        wait_idle(100);
        check_flag("error", error, 1'b0);
        check_count("rx_count", rx_count, fifo_count_t'(2 * BLOCK_BYTES));
        drain_rx(2 * BLOCK_BYTES);
        check_flag("rx_empty", rx_empty, 1'b1);

        fill_random(BLOCK_BYTES);  // One CRC bit flipped on DAT2
        blocks = 8'd0;
        issue_start(1'b0);
        send_frame(0, 2, 5, BLOCK_NIBBLES);
        wait_idle(100);
        check_flag("error", error, 1'b1);
        pulse_flush();

        // ==================================================
        // Writes
        // ==================================================

        fill_random(2 * BLOCK_BYTES);
        load_tx(2 * BLOCK_BYTES);
        check_flag("tx_full", tx_full, 1'b1);
        blocks = 8'd1;
        issue_start(1'b1);
        for (i = 0; i < 2; i++) begin
            capture_frame(i * BLOCK_BYTES);
            send_token(3'b010);
        end
        wait_idle(100);
        check_flag("error", error, 1'b0);
        check_count("tx_count", tx_count, '0);

        fill_random(BLOCK_BYTES);  // Token 1,0,1
        load_tx(BLOCK_BYTES);
        blocks = 8'd0;
        issue_start(1'b1);
        capture_frame(0);
        send_token(3'b101);
        wait_idle(100);
        check_flag("error", error, 1'b1);

        fill_random(BLOCK_BYTES);  // Card never answers
        load_tx(BLOCK_BYTES);
        issue_start(1'b1);
        capture_frame(0);
        wait_idle(400);
        check_flag("error", error, 1'b1);
        check_flag("dat_oe", dat_oe, 1'b0);

        // ==================================================
        // Stop, flush and card busy
        // ==================================================

        fill_random(BLOCK_BYTES);
        issue_start(1'b0);
        send_frame(0, -1, 0, 200);
        @(posedge sd_clk_rising);
        tick();
        tick();
        check_count("rx_count", rx_count, fifo_count_t'(100));
        stop = 1'b1;
        tick();
        stop = 1'b0;
        check_flag("busy", busy, 1'b0);
        dat_in = 4'hF;
        load_tx(10);
        check_count("tx_count", tx_count, fifo_count_t'(10));
        pulse_flush();
        check_count("rx_count", rx_count, '0);
        check_count("tx_count", tx_count, '0);
        check_flag("rx_empty", rx_empty, 1'b1);

        dat_in = 4'hE;  // Card holds DAT0 low
        tick();
        for (i = 0; i < 6; i++) begin
            tick();
            check_flag("card_busy", card_busy, 1'b1);
        end
        dat_in = 4'hF;
        tick();
        for (i = 0; i < 6; i++) begin
            tick();
            check_flag("card_busy", card_busy, 1'b0);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* all.f */
logic/sd_dat_pkg.sv
logic/sd_fifo_if.sv
logic/sd_crc16.sv
logic/sd_byte_fifo.sv
logic/sd_dat_rx.sv
logic/sd_dat_tx.sv
logic/sd_dat.sv
test/sd_dat_sva.sv
test/sd_dat_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sd_dat_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
